// File: src/rv32_fetch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch types and constants, RV32IC only
// Memory is little-endian, word addressed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package rv32_fetch_pkg;

  // Address or full instruction word
  typedef logic [31:0] word_t;

  // One 16-bit instruction parcel
  typedef logic [15:0] half_t;

  // BTB index, pc bits 5:2
  typedef logic [3:0] btb_idx_t;

  // First fetch address after reset
  localparam word_t RESET_PC = 32'h8000_0000;

  // BTB geometry
  localparam int BTB_ENTRIES = 16;
  // Tag covers pc bits 31:6
  localparam int BTB_TAG_W = 26;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  // Realignment buffer states
  // IDLE_ALIGNED  nothing held, read word at pc
  // HAVE_UPPER    held parcel is a whole compressed instruction
  // NEED_UPPER    held parcel is the low half of a 32-bit instruction
  typedef enum logic [1:0] {
    IDLE_ALIGNED = 2'd0,
    HAVE_UPPER   = 2'd1,
    NEED_UPPER   = 2'd2
  } fbuf_state_e;

endpackage

`default_nettype wire

// File: src/fetch_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Builds 16/32-bit instructions from word reads
// pc bit 0 is ignored here and flagged by the stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
  input  logic                  CLK,
  input  logic                  nRST,
  input  rv32_fetch_pkg::word_t rdata,
  input  logic                  rd_done,
  input  logic                  pc_update,
  input  logic                  reset_en,
  input  rv32_fetch_pkg::word_t reset_pc,
  output rv32_fetch_pkg::word_t nextpc,
  output rv32_fetch_pkg::word_t countread,
  output rv32_fetch_pkg::word_t result,
  output logic                  done
);
  import rv32_fetch_pkg::*;

  fbuf_state_e state;
  fbuf_state_e hold_state;
  word_t       pc_q;
  word_t       pc_word;
  half_t       upper;
  logic        raw_done;
  logic        first_is_rvc;
  logic        jump;

  // Word holding the current instruction's first parcel
  assign pc_word = {pc_q[31:2], 2'b00};

  // Next state once the upper half of rdata is kept
  assign hold_state = (rdata[17:16] == 2'b11) ? NEED_UPPER : HAVE_UPPER;

  // Held parcel sits in the upper half, so the bus looks one word ahead
  assign countread = (state == IDLE_ALIGNED) ? pc_word : (pc_word + 32'd4);

  // Instruction assembly
  always_comb begin
    raw_done = 1'b0;
    result   = {16'h0000, rdata[31:16]};
    case (state)
      IDLE_ALIGNED: begin
        if (!pc_q[1]) begin
          // Aligned start takes the whole word or the low parcel
          if (rdata[1:0] == 2'b11) begin
            result = rdata;
          end else begin
            result = {16'h0000, rdata[15:0]};
          end
          raw_done = rd_done;
        end
        // Odd halfword start just fills the holding parcel
      end
      HAVE_UPPER: begin
        // Parcel already buffered so no bus completion needed
        result   = {16'h0000, upper};
        raw_done = 1'b1;
      end
      NEED_UPPER: begin
        // Straddling instruction with its low half held
        result   = {rdata[15:0], upper};
        raw_done = rd_done;
      end
      default: begin
        raw_done = 1'b0;
      end
    endcase
  end

  // A redirect cancels whatever is being assembled
  assign done = raw_done & ~reset_en;

  assign first_is_rvc = (result[1:0] != 2'b11);
  assign nextpc       = pc_q + (first_is_rvc ? 32'd2 : 32'd4);

  // Predicted or forced target that breaks the sequential walk
  assign jump = reset_en || (reset_pc != nextpc);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE_ALIGNED;
      pc_q  <= RESET_PC;
    end else if (pc_update) begin
      pc_q <= reset_pc;
      if (jump) begin
        // Held parcel belongs to the old path
        state <= IDLE_ALIGNED;
      end else begin
        case (state)
          IDLE_ALIGNED: state <= first_is_rvc ? hold_state : IDLE_ALIGNED;
          HAVE_UPPER:   state <= IDLE_ALIGNED;
          NEED_UPPER:   state <= hold_state;
          default:      state <= IDLE_ALIGNED;
        endcase
      end
    end else if (rd_done && (state == IDLE_ALIGNED) && pc_q[1]) begin
      // First read after a jump to an odd halfword
      state <= hold_state;
    end
  end

  // Upper parcel of the most recent word
  always_ff @(posedge CLK) begin
    if (rd_done && (state != HAVE_UPPER)) begin
      upper <= rdata[31:16];
    end
  end

  // A held parcel always belongs to an odd halfword pc
  assert property (@(posedge CLK) disable iff (!nRST) (state != IDLE_ALIGNED) |-> pc_q[1])
    else $error("fetch_buffer: parcel held at a word-aligned pc");

endmodule

`default_nettype wire

// File: src/btb_predictor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-entry direct-mapped BTB whose tag ignores pc[1]
// Two halfwords of one word share an entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module btb_predictor (
  input  logic                  CLK,
  input  logic                  nRST,
  input  rv32_fetch_pkg::word_t current_pc,
  output logic                  predict_taken,
  output rv32_fetch_pkg::word_t target_addr,
  input  logic                  upd_en,
  input  rv32_fetch_pkg::word_t upd_pc,
  input  rv32_fetch_pkg::word_t upd_target,
  input  logic                  upd_taken
);
  import rv32_fetch_pkg::*;

  // Entry storage
  logic [BTB_ENTRIES-1:0] valid;
  logic [BTB_ENTRIES-1:0] taken_mem;
  logic [BTB_TAG_W-1:0]   tag_mem [BTB_ENTRIES];
  word_t                  target_mem [BTB_ENTRIES];

  btb_idx_t             rd_idx;
  btb_idx_t             wr_idx;
  logic [BTB_TAG_W-1:0] rd_tag;
  logic [BTB_TAG_W-1:0] wr_tag;
  logic                 tag_hit;

  // Lookup side
  assign rd_idx = current_pc[5:2];
  assign rd_tag = current_pc[31:6];

  // Training side
  assign wr_idx = upd_pc[5:2];
  assign wr_tag = upd_pc[31:6];

  // Combinational lookup on current pc
  assign tag_hit       = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign predict_taken = tag_hit && taken_mem[rd_idx];
  assign target_addr   = target_mem[rd_idx];

  // Entry turns valid on its first training write
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (upd_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // Training overwrites the whole entry
  always_ff @(posedge CLK) begin
    if (upd_en) begin
      taken_mem[wr_idx]  <= upd_taken;
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= upd_target;
    end
  end

  // Trained targets must be legal RV32IC fetch addresses
  assert property (@(posedge CLK) disable iff (!nRST) predict_taken |-> !target_addr[0])
    else $error("btb_predictor: predicted target not halfword aligned");

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC, next-PC select and fetch/execute register
// Redirects flush the register on the same edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  // Hazard and execute side
  input  logic                  ex_stall,
  input  logic                  npc_sel,
  input  rv32_fetch_pkg::word_t brj_addr,
  input  logic                  insert_priv_pc,
  input  rv32_fetch_pkg::word_t priv_pc,
  // Instruction memory
  output rv32_fetch_pkg::word_t imem_addr,
  output logic                  imem_ren,
  input  rv32_fetch_pkg::word_t imem_rdata,
  input  logic                  imem_busy,
  // Fetch to execute
  output logic                  fe_token,
  output rv32_fetch_pkg::word_t fe_pc,
  output rv32_fetch_pkg::word_t fe_pc4,
  output rv32_fetch_pkg::word_t fe_instr,
  output logic                  fe_prediction,
  output logic                  mal_insn,
  output rv32_fetch_pkg::word_t badaddr_f,
  // Predictor
  output rv32_fetch_pkg::word_t current_pc,
  input  logic                  predict_taken,
  input  rv32_fetch_pkg::word_t target_addr,
  // Realignment buffer
  output rv32_fetch_pkg::word_t rdata,
  output logic                  rd_done,
  output logic                  pc_update,
  output logic                  reset_en,
  output rv32_fetch_pkg::word_t reset_pc,
  input  rv32_fetch_pkg::word_t result,
  input  logic                  done,
  input  rv32_fetch_pkg::word_t nextpc,
  input  rv32_fetch_pkg::word_t countread
);
  import rv32_fetch_pkg::*;

  word_t pc;
  word_t npc;
  logic  redirect;
  logic  pc_en;
  logic  advance;
  logic  ren_q;

  // Execute or privileged redirect
  assign redirect = npc_sel | insert_priv_pc;

  // Next PC priority, privileged first
  always_comb begin
    if (insert_priv_pc) begin
      npc = priv_pc;
    end else if (npc_sel) begin
      npc = brj_addr;
    end else if (predict_taken) begin
      npc = target_addr;
    end else begin
      npc = nextpc;
    end
  end

  // Instruction leaves fetch this edge
  assign advance = done & ~ex_stall;
  assign pc_en   = advance | redirect;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (pc_en) begin
      pc <= npc;
    end
  end

  // Read enable comes up the first edge out of reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ren_q <= 1'b0;
    end else begin
      ren_q <= 1'b1;
    end
  end

  // Bus side, address comes from the buffer
  assign imem_ren  = ren_q;
  assign imem_addr = countread;
  assign rdata     = imem_rdata;
  // Stalled completions are dropped and the word is read again
  assign rd_done   = imem_ren & ~imem_busy & ~ex_stall;

  // Buffer control
  assign pc_update = pc_en;
  assign reset_en  = redirect;
  assign reset_pc  = npc;

  assign current_pc = pc;

  // Token pulses once per delivered instruction
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fe_token <= 1'b0;
    end else if (redirect) begin
      fe_token <= 1'b0;
    end else if (!ex_stall) begin
      fe_token <= done;
    end
  end

  // Register payload
  always_ff @(posedge CLK) begin
    if (redirect) begin
      fe_instr      <= NOP_INSTR;
      fe_prediction <= 1'b0;
    end else if (advance) begin
      fe_pc         <= pc;
      fe_pc4        <= nextpc;
      fe_instr      <= result;
      fe_prediction <= predict_taken;
    end
  end

  // Odd pc is the only fetch fault
  assign mal_insn  = pc[0];
  assign badaddr_f = pc;

  // Buffer only ever asks for whole words
  assert property (@(posedge CLK) disable iff (!nRST) imem_addr[1:0] == 2'b00)
    else $error("fetch_stage: unaligned memory read address");

endmodule

`default_nettype wire

// File: src/fetch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch side of the two-stage pipeline
// Execute and hazard signals are plain inputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                  CLK,
  input  logic                  nRST,
  // Instruction memory
  output rv32_fetch_pkg::word_t imem_addr,
  output logic                  imem_ren,
  input  rv32_fetch_pkg::word_t imem_rdata,
  input  logic                  imem_busy,
  // Execute and hazard
  input  logic                  ex_stall,
  input  logic                  npc_sel,
  input  rv32_fetch_pkg::word_t brj_addr,
  input  logic                  insert_priv_pc,
  input  rv32_fetch_pkg::word_t priv_pc,
  // BTB training from execute
  input  logic                  upd_en,
  input  rv32_fetch_pkg::word_t upd_pc,
  input  rv32_fetch_pkg::word_t upd_target,
  input  logic                  upd_taken,
  // Fetch to execute
  output logic                  fe_token,
  output rv32_fetch_pkg::word_t fe_pc,
  output rv32_fetch_pkg::word_t fe_pc4,
  output rv32_fetch_pkg::word_t fe_instr,
  output logic                  fe_prediction,
  output logic                  mal_insn,
  output rv32_fetch_pkg::word_t badaddr_f
);

  // Stage to buffer
  rv32_fetch_pkg::word_t rdata;
  logic                  rd_done;
  logic                  pc_update;
  logic                  reset_en;
  rv32_fetch_pkg::word_t reset_pc;

  // Buffer to stage
  rv32_fetch_pkg::word_t result;
  logic                  done;
  rv32_fetch_pkg::word_t nextpc;
  rv32_fetch_pkg::word_t countread;

  // Stage and predictor
  rv32_fetch_pkg::word_t current_pc;
  logic                  predict_taken;
  rv32_fetch_pkg::word_t target_addr;

  fetch_stage u_stage (
    .CLK            (CLK),
    .nRST           (nRST),
    .ex_stall       (ex_stall),
    .npc_sel        (npc_sel),
    .brj_addr       (brj_addr),
    .insert_priv_pc (insert_priv_pc),
    .priv_pc        (priv_pc),
    .imem_addr      (imem_addr),
    .imem_ren       (imem_ren),
    .imem_rdata     (imem_rdata),
    .imem_busy      (imem_busy),
    .fe_token       (fe_token),
    .fe_pc          (fe_pc),
    .fe_pc4         (fe_pc4),
    .fe_instr       (fe_instr),
    .fe_prediction  (fe_prediction),
    .mal_insn       (mal_insn),
    .badaddr_f      (badaddr_f),
    .current_pc     (current_pc),
    .predict_taken  (predict_taken),
    .target_addr    (target_addr),
    .rdata          (rdata),
    .rd_done        (rd_done),
    .pc_update      (pc_update),
    .reset_en       (reset_en),
    .reset_pc       (reset_pc),
    .result         (result),
    .done           (done),
    .nextpc         (nextpc),
    .countread      (countread)
  );

  fetch_buffer u_buffer (
    .CLK       (CLK),
    .nRST      (nRST),
    .rdata     (rdata),
    .rd_done   (rd_done),
    .pc_update (pc_update),
    .reset_en  (reset_en),
    .reset_pc  (reset_pc),
    .nextpc    (nextpc),
    .countread (countread),
    .result    (result),
    .done      (done)
  );

  // Training port passes straight through
  btb_predictor u_btb (
    .CLK           (CLK),
    .nRST          (nRST),
    .current_pc    (current_pc),
    .predict_taken (predict_taken),
    .target_addr   (target_addr),
    .upd_en        (upd_en),
    .upd_pc        (upd_pc),
    .upd_target    (upd_target),
    .upd_taken     (upd_taken)
  );

endmodule

`default_nettype wire

// File: testbench/fetch_tb_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Included inside fetch_tb and uses its signals
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FETCH_TB_TASKS_SVH
`define FETCH_TB_TASKS_SVH

// Galois LFSR with taps 16 14 13 11
function automatic logic lfsr_bit();
  logic b;
  b = lfsr_q[0];
  lfsr_q = b ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
  return b;
endfunction

function automatic word_t addi_instr(input int k);
  return {k[11:0], 5'd1, 3'd0, 5'd1, 7'h13};
endfunction

function automatic half_t get_half(input word_t addr);
  word_t w;
  w = mem[addr[9:2]];
  return addr[1] ? w[31:16] : w[15:0];
endfunction

// Expected instruction from the low-bits rule
function automatic word_t exp_instr(input word_t pc);
  half_t h0;
  h0 = get_half(pc);
  if (h0[1:0] == 2'b11) return {get_half(pc + 32'd2), h0};
  return {16'h0000, h0};
endfunction

function automatic word_t exp_size(input word_t pc);
  half_t h0;
  h0 = get_half(pc);
  return (h0[1:0] == 2'b11) ? 32'd4 : 32'd2;
endfunction

// Background pattern from the full word address
task automatic fill_mem();
  word_t a;
  for (int i = 0; i < 256; i++) begin
    a = RESET_PC + 32'(i * 4);
    mem[i] = (a * 32'h9E37_79B1) | 32'h0000_0003;
  end
endtask

task automatic put_half(input word_t addr, input half_t h);
  if (addr[1]) mem[addr[9:2]][31:16] = h;
  else mem[addr[9:2]][15:0] = h;
endtask

task automatic load_seq32(input int n);
  for (int k = 0; k < n; k++) mem[k] = addi_instr(k);
endtask

task automatic flush_tokens();
  tok_pc.delete();
  tok_pc4.delete();
  tok_instr.delete();
  tok_pred.delete();
endtask

task automatic apply_reset();
  @(posedge CLK);
  #2;
  nRST = 1'b0;
  repeat (4) @(posedge CLK);
  #2;
  nRST = 1'b1;
  flush_tokens();
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
  if (got !== exp) begin
    $display("error %0t %s got %h expected %h", $time, name, got, exp);
    err_count++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("error %0t %s got %b expected %b", $time, name, got, exp);
    err_count++;
  end
endtask

// Wait bounded at 40 cycles per token
task automatic wait_tokens(input int n);
  int cycles;
  cycles = 0;
  while (tok_pc.size() < n && cycles < 40 * n) begin
    @(negedge CLK);
    cycles++;
  end
  if (tok_pc.size() < n) begin
    $display("Timed out at %0t waiting for %0d tokens, saw %0d", $time, n, tok_pc.size());
    err_count++;
  end
endtask

// Sequential walk from start with no predictions
task automatic check_stream(input word_t start, input int n);
  word_t pc;
  pc = start;
  for (int i = 0; i < n && i < tok_pc.size(); i++) begin
    check_word("fe_pc", tok_pc[i], pc);
    check_word("fe_pc4", tok_pc4[i], pc + exp_size(pc));
    check_word("fe_instr", tok_instr[i], exp_instr(pc));
    check_bit("fe_prediction", tok_pred[i], 1'b0);
    pc = pc + exp_size(pc);
  end
endtask

task automatic redirect_to(input logic use_br, input word_t br,
                           input logic use_priv, input word_t pv);
  @(posedge CLK);
  #2;
  npc_sel        = use_br;
  brj_addr       = br;
  insert_priv_pc = use_priv;
  priv_pc        = pv;
  @(posedge CLK);
  #2;
  npc_sel        = 1'b0;
  insert_priv_pc = 1'b0;
  flush_tokens();
endtask

task automatic train_btb(input word_t pc, input word_t target, input logic taken);
  @(posedge CLK);
  #2;
  upd_en     = 1'b1;
  upd_pc     = pc;
  upd_target = target;
  upd_taken  = taken;
  @(posedge CLK);
  #2;
  upd_en = 1'b0;
endtask

task automatic end_test(input string name, input int errs_before);
  test_count++;
  if (err_count == errs_before) begin
    $display("%s: ok", name);
  end else begin
    bad_tests++;
    $display("%s: %0d errors", name, err_count - errs_before);
  end
endtask

task automatic test_reset_state();
  int e;
  e = err_count;
  fill_mem();
  mem[0] = addi_instr(7);
  apply_reset();
  // First edge only raises the read enable
  @(negedge CLK);
  check_bit("fe_token", fe_token, 1'b0);
  check_bit("mal_insn", mal_insn, 1'b0);
  check_bit("imem_ren", imem_ren, 1'b0);
  check_word("imem_addr", imem_addr, RESET_PC);
  wait_tokens(1);
  check_bit("imem_ren", imem_ren, 1'b1);
  if (tok_pc.size() > 0) begin
    check_word("fe_pc", tok_pc[0], RESET_PC);
    check_word("fe_instr", tok_instr[0], mem[0]);
  end
  end_test("reset_state", e);
endtask

task automatic test_seq32();
  int e;
  e = err_count;
  fill_mem();
  load_seq32(8);
  apply_reset();
  wait_tokens(8);
  check_stream(RESET_PC, 8);
  end_test("seq32", e);
endtask

task automatic test_mixed();
  int    e;
  int    sizes [8];
  word_t a;
  word_t w;
  e = err_count;
  // 32-bit at +2, +10 and +14 straddle word boundaries
  sizes = '{2, 4, 2, 2, 4, 4, 2, 4};
  fill_mem();
  a = RESET_PC;
  for (int k = 0; k < 8; k++) begin
    if (sizes[k] == 2) begin
      put_half(a, 16'h0001 | 16'(k << 2));
    end else begin
      w = addi_instr(k + 16);
      put_half(a, w[15:0]);
      put_half(a + 32'd2, w[31:16]);
    end
    a = a + 32'(sizes[k]);
  end
  apply_reset();
  wait_tokens(8);
  check_stream(RESET_PC, 8);
  end_test("mixed", e);
endtask

task automatic test_redirect();
  int e;
  e = err_count;
  load_seq32(256);
  apply_reset();
  wait_tokens(2);
  redirect_to(1'b1, RESET_PC + 32'h30, 1'b0, '0);
  wait_tokens(3);
  check_stream(RESET_PC + 32'h30, 3);
  redirect_to(1'b0, '0, 1'b1, RESET_PC + 32'h80);
  wait_tokens(3);
  check_stream(RESET_PC + 32'h80, 3);
  // Privileged redirect wins over execute
  redirect_to(1'b1, RESET_PC + 32'h100, 1'b1, RESET_PC + 32'h200);
  wait_tokens(3);
  check_stream(RESET_PC + 32'h200, 3);
  end_test("redirect", e);
endtask

task automatic test_btb();
  int    e;
  word_t x;
  word_t y;
  e = err_count;
  x = RESET_PC + 32'h8;
  y = RESET_PC + 32'h40;
  load_seq32(256);
  apply_reset();
  train_btb(x, y, 1'b1);
  redirect_to(1'b1, RESET_PC, 1'b0, '0);
  wait_tokens(5);
  if (tok_pc.size() >= 5) begin
    check_stream(RESET_PC, 2);
    check_word("fe_pc", tok_pc[2], x);
    check_bit("fe_prediction", tok_pred[2], 1'b1);
    check_word("fe_pc", tok_pc[3], y);
    check_word("fe_pc", tok_pc[4], y + 32'd4);
  end
  train_btb(x, y, 1'b0);
  redirect_to(1'b1, RESET_PC, 1'b0, '0);
  wait_tokens(4);
  check_stream(RESET_PC, 4);
  end_test("btb", e);
endtask

task automatic test_mal_stall();
  int    e;
  word_t s_pc;
  word_t s_pc4;
  word_t s_instr;
  logic  s_tok;
  logic  s_pred;
  e = err_count;
  load_seq32(256);
  apply_reset();
  wait_tokens(1);
  redirect_to(1'b1, RESET_PC + 32'h21, 1'b0, '0);
  check_bit("mal_insn", mal_insn, 1'b1);
  check_word("badaddr_f", badaddr_f, RESET_PC + 32'h21);
  check_bit("fe_token", fe_token, 1'b0);
  check_word("fe_instr", fe_instr, NOP_INSTR);
  redirect_to(1'b1, RESET_PC, 1'b0, '0);
  wait_tokens(2);
  @(posedge CLK);
  #2;
  ex_stall = 1'b1;
  // Values present now are the ones frozen by the stall
  @(negedge CLK);
  s_tok   = fe_token;
  s_pc    = fe_pc;
  s_pc4   = fe_pc4;
  s_instr = fe_instr;
  s_pred  = fe_prediction;
  repeat (5) begin
    @(negedge CLK);
    check_bit("fe_token", fe_token, s_tok);
    check_word("fe_pc", fe_pc, s_pc);
    check_word("fe_pc4", fe_pc4, s_pc4);
    check_word("fe_instr", fe_instr, s_instr);
    check_bit("fe_prediction", fe_prediction, s_pred);
  end
  @(posedge CLK);
  #2;
  ex_stall = 1'b0;
  wait_tokens(4);
  check_stream(RESET_PC, 4);
  end_test("mal_stall", e);
endtask

`endif

// File: testbench/fetch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch testbench, 1 KB word memory aliased over the bus
// Busy cycles come from a seeded LFSR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
  import rv32_fetch_pkg::*;

  localparam int CLK_HALF = 20;
  // Tokens checked over all tests
  localparam int TOTAL_INSTR = 1 + 8 + 8 + 9 + 9 + 4;
  localparam int WATCHDOG_NS = 40 * TOTAL_INSTR * 8;

  logic  CLK;
  logic  nRST;
  word_t imem_addr;
  logic  imem_ren;
  word_t imem_rdata;
  logic  imem_busy;
  logic  ex_stall;
  logic  npc_sel;
  word_t brj_addr;
  logic  insert_priv_pc;
  word_t priv_pc;
  logic  upd_en;
  word_t upd_pc;
  word_t upd_target;
  logic  upd_taken;
  logic  fe_token;
  word_t fe_pc;
  word_t fe_pc4;
  word_t fe_instr;
  logic  fe_prediction;
  logic  mal_insn;
  word_t badaddr_f;

  // Memory image, indexed by address bits 9:2
  word_t mem [256];

  // Tokens seen by the monitor
  word_t tok_pc[$];
  word_t tok_pc4[$];
  word_t tok_instr[$];
  logic  tok_pred[$];

  logic [15:0] lfsr_q;
  int          err_count;
  int          test_count;
  int          bad_tests;
  logic        stall_last;
  logic        read_seen;
  int          busy_cnt;

  `include "fetch_tb_tasks.svh"

  fetch_top u_fetch_top (
    .CLK            (CLK),
    .nRST           (nRST),
    .imem_addr      (imem_addr),
    .imem_ren       (imem_ren),
    .imem_rdata     (imem_rdata),
    .imem_busy      (imem_busy),
    .ex_stall       (ex_stall),
    .npc_sel        (npc_sel),
    .brj_addr       (brj_addr),
    .insert_priv_pc (insert_priv_pc),
    .priv_pc        (priv_pc),
    .upd_en         (upd_en),
    .upd_pc         (upd_pc),
    .upd_target     (upd_target),
    .upd_taken      (upd_taken),
    .fe_token       (fe_token),
    .fe_pc          (fe_pc),
    .fe_pc4         (fe_pc4),
    .fe_instr       (fe_instr),
    .fe_prediction  (fe_prediction),
    .mal_insn       (mal_insn),
    .badaddr_f      (badaddr_f)
  );

  initial begin
    CLK = 1'b0;
    forever #CLK_HALF CLK = ~CLK;
  end

  // Read data follows the address with no latency
  always_comb begin
    imem_rdata = mem[imem_addr[9:2]];
  end

  // Busy model, 0 to 3 wait cycles after each completed read
  initial begin
    imem_busy = 1'b0;
    busy_cnt  = 0;
    forever begin
      @(negedge CLK);
      read_seen = imem_ren && !imem_busy;
      @(posedge CLK);
      #2;
      if (read_seen) begin
        busy_cnt = 0;
        if (lfsr_bit()) busy_cnt = busy_cnt + 2;
        if (lfsr_bit()) busy_cnt = busy_cnt + 1;
      end else if (busy_cnt > 0) begin
        busy_cnt = busy_cnt - 1;
      end
      imem_busy = (busy_cnt != 0);
    end
  end

  // New token only when the previous edge was not stalled
  always @(negedge CLK) begin
    if (fe_token && !stall_last) begin
      tok_pc.push_back(fe_pc);
      tok_pc4.push_back(fe_pc4);
      tok_instr.push_back(fe_instr);
      tok_pred.push_back(fe_prediction);
    end
    stall_last = ex_stall;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    lfsr_q     = 16'd64533;
    err_count  = 0;
    test_count = 0;
    bad_tests  = 0;
    stall_last = 1'b0;
    read_seen  = 1'b0;
    nRST           = 1'b0;
    ex_stall       = 1'b0;
    npc_sel        = 1'b0;
    brj_addr       = '0;
    insert_priv_pc = 1'b0;
    priv_pc        = '0;
    upd_en         = 1'b0;
    upd_pc         = '0;
    upd_target     = '0;
    upd_taken      = 1'b0;
    fill_mem();

    test_reset_state();
    test_seq32();
    test_mixed();
    test_redirect();
    test_btb();
    test_mal_stall();

    $display("tests %0d, tests with errors %0d, mismatches %0d",
             test_count, bad_tests, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv32_fetch.f
+incdir+testbench
src/rv32_fetch_pkg.sv
src/fetch_buffer.sv
src/btb_predictor.sv
src/fetch_stage.sv
src/fetch_top.sv
testbench/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f rv32_fetch.f --top-module fetch_tb \
  -o fetch_sim \
  && ./obj_dir/fetch_sim 2>&1 | tee "$LOG" \
  || { echo "Build or run error"; exit 1; }

grep -q "Simulation failed" "$LOG" \
  && { echo "Run reported failure"; exit 1; } \
  || { echo "Run clean"; exit 0; }
